//--- dv/tb_tile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile import swarm_pkg::*; ();

   localparam int TIMEOUT = 200;

   logic        clk;
   logic        rstn;
   logic        ocl_awvalid;
   logic        ocl_awready;
   logic [15:0] ocl_awaddr;
   logic        ocl_wvalid;
   logic        ocl_wready;
   logic [31:0] ocl_wdata;
   logic        ocl_bvalid;
   logic        ocl_bready;
   logic        ocl_arvalid;
   logic        ocl_arready;
   logic [15:0] ocl_araddr;
   logic        ocl_rvalid;
   logic        ocl_rready;
   logic [31:0] ocl_rdata;

   int          n_checks;
   int          n_errors;
   logic [31:0] unit_model [ID_LAST][N_TILE_REGS];   // Expected tile_regs contents

   tile_top DUT (
      .clk(clk), .rstn(rstn),
      .ocl_awvalid(ocl_awvalid), .ocl_awready(ocl_awready), .ocl_awaddr(ocl_awaddr),
      .ocl_wvalid(ocl_wvalid), .ocl_wready(ocl_wready), .ocl_wdata(ocl_wdata),
      .ocl_bvalid(ocl_bvalid), .ocl_bready(ocl_bready),
      .ocl_arvalid(ocl_arvalid), .ocl_arready(ocl_arready), .ocl_araddr(ocl_araddr),
      .ocl_rvalid(ocl_rvalid), .ocl_rready(ocl_rready), .ocl_rdata(ocl_rdata)
   );

   always #20 clk = ~clk;   // 40 ns period

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      n_errors++;
      $display("timeout at %0t ns waiting for %s", $time, what);
   endtask

   // Ready sampled at the falling edge and the transfer made on the next rising edge
   task automatic host_write(input logic [15:0] addr, input logic [31:0] data,
                             input int delay, output int lat);
      int t;
      @(negedge clk);
      ocl_awvalid = 1'b1;
      ocl_awaddr = addr;
      t = 0;
      while (!ocl_awready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!ocl_awready) report_timeout("awready");
      @(negedge clk);
      ocl_awvalid = 1'b0;
      ocl_wvalid = 1'b1;
      ocl_wdata = data;
      t = 0;
      while (!ocl_wready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!ocl_wready) report_timeout("wready");
      @(negedge clk);
      ocl_wvalid = 1'b0;
      lat = 1;                                  // Cycles since the W transfer
      while (!ocl_bvalid && lat < TIMEOUT) begin
         @(negedge clk);
         lat++;
      end
      if (!ocl_bvalid) report_timeout("bvalid");
      for (t = 0; t < delay; t++) begin
         @(negedge clk);
         if (!ocl_bvalid) begin
            n_errors++;
            $display("bvalid dropped at %0t ns while bready was low", $time);
         end
      end
      ocl_bready = 1'b1;
      @(negedge clk);
      ocl_bready = 1'b0;
   endtask

   task automatic host_read(input logic [15:0] addr, input int delay,
                            output logic [31:0] data, output int lat);
      int t;
      @(negedge clk);
      ocl_arvalid = 1'b1;
      ocl_araddr = addr;
      t = 0;
      while (!ocl_arready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!ocl_arready) report_timeout("arready");
      @(negedge clk);
      ocl_arvalid = 1'b0;
      lat = 1;                                  // Cycles since the AR transfer
      while (!ocl_rvalid && lat < TIMEOUT) begin
         @(negedge clk);
         lat++;
      end
      if (!ocl_rvalid) report_timeout("rvalid");
      data = ocl_rdata;
      for (t = 0; t < delay; t++) begin
         @(negedge clk);
         if (!ocl_rvalid) begin
            n_errors++;
            $display("rvalid dropped at %0t ns while rready was low", $time);
         end
         if (ocl_rdata !== data) begin
            n_errors++;
            $display("mismatch at %0t ns: rdata changed under back-pressure", $time);
         end
      end
      ocl_rready = 1'b1;
      @(negedge clk);
      ocl_rready = 1'b0;
   endtask

   task automatic regs_readback();
      logic [31:0] d;
      logic [31:0] got;
      logic [7:0]  off;
      int          lat;
      int          u;
      int          k;
      for (u = 1; u < ID_LAST; u++) begin
         for (k = 0; k < 4; k++) begin
            off = {2'b00, 4'($urandom_range(0, 14)), 2'b00};   // Keep clear of DONE_OFFSET
            d = $urandom;
            host_write({8'(u), off}, d, 0, lat);
            unit_model[u][off[5:2]] = d;
         end
      end
      off = {2'b00, 4'($urandom_range(0, 14)), 2'b00};
      d = $urandom;
      host_write({ID_ALL_UNITS, off}, d, 0, lat);
      unit_model[1][off[5:2]] = d;
      unit_model[2][off[5:2]] = d;
      for (u = 1; u < ID_LAST; u++) begin
         for (k = 0; k < N_TILE_REGS - 1; k++) begin
            host_read({8'(u), 8'(k * 4)}, 0, got, lat);
            check_word($sformatf("unit %0d reg %0d", u, k), got, unit_model[u][k]);
         end
         check_word("unit read latency", 32'(lat), 32'd3);
      end
   endtask

   task automatic task_fifo_order();
      logic [31:0] ts_exp [$];
      logic [31:0] loc_exp [$];
      logic [31:0] ts;
      logic [31:0] loc;
      logic [31:0] got;
      logic [31:0] last_loc;
      int          lat;
      int          i;
      last_loc = '0;
      for (i = 0; i < 3; i++) begin
         ts = $urandom;
         loc = $urandom;
         host_write({8'h00, OCL_TASK_ENQ_LOCALE}, loc, 0, lat);
         host_write({8'h00, OCL_TASK_ENQ_TTYPE}, 32'(i), 0, lat);
         host_write({8'h00, OCL_TASK_ENQ}, ts, 0, lat);
         ts_exp.push_back(ts);
         loc_exp.push_back(loc);
      end
      host_write({8'h00, OCL_TASK_ENQ_LOCALE}, ~loc, 0, lat);   // Each pop replaces this
      while (ts_exp.size() > 0) begin
         host_read({8'h00, OCL_TASK_ENQ}, 0, got, lat);
         check_word("dequeued ts", got, ts_exp.pop_front());
         last_loc = loc_exp.pop_front();
      end
      host_read({8'h00, OCL_TASK_ENQ_LOCALE}, 0, got, lat);
      check_word("popped locale", got, last_loc);
      host_read({8'h00, OCL_TASK_ENQ}, 0, got, lat);
      check_word("empty queue ts", got, 32'hFFFF_FFFF);
   endtask

   task automatic l1_window();
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] d1;
      logic [31:0] d2;
      logic [31:0] got;
      int          lat;
      a1 = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
      a2 = a1 ^ 32'h0000_0040;                  // Another word in L1
      d1 = $urandom;
      d2 = $urandom;
      host_write({8'h00, OCL_MEM_ADDR}, a1, 0, lat);
      check_word("unit 0 write latency", 32'(lat), 32'd2);
      host_write({8'h00, OCL_ACCESS_MEM}, d1, 0, lat);
      host_write({8'h00, OCL_MEM_ADDR}, a2, 0, lat);
      host_write({8'h00, OCL_ACCESS_MEM}, d2, 0, lat);
      host_write({8'h00, OCL_MEM_ADDR}, a1, 0, lat);
      host_read({8'h00, OCL_ACCESS_MEM}, 0, got, lat);
      check_word("L1 word at first address", got, d1);
      host_write({8'h00, OCL_MEM_ADDR}, a2, 0, lat);
      host_read({8'h00, OCL_ACCESS_MEM}, 0, got, lat);
      check_word("L1 word at second address", got, d2);
      host_read({8'h00, OCL_LAST_MEM_LATENCY}, 0, got, lat);
      check_word("last memory latency", got, 32'(L1_LATENCY));
   endtask

   task automatic counter_and_params();
      logic [31:0] c0;
      logic [31:0] c1;
      logic [31:0] got;
      int          lat;
      host_read({8'h00, OCL_CUR_CYCLE_LSB}, 0, c0, lat);
      check_word("unit 0 read latency", 32'(lat), 32'd3);
      host_read({8'h00, OCL_CUR_CYCLE_LSB}, 0, c1, lat);
      n_checks++;
      if (!(c1 > c0 && c1 - c0 >= 32'd3)) begin
         n_errors++;
         $display("mismatch at %0t ns: cycle counter went from %0d to %0d", $time, c0, c1);
      end
      host_read({8'h00, OCL_CUR_CYCLE_MSB}, 0, got, lat);
      check_word("cycle counter msb", got, 32'd0);
      host_read({8'h00, OCL_PARAM_N_UNITS}, 0, got, lat);
      check_word("unit count", got, 32'(N_UNITS));
   endtask

   task automatic done_summary();
      logic [31:0] got;
      int          lat;
      host_write({8'h02, DONE_OFFSET}, $urandom | 32'd1, 0, lat);
      host_read({8'h00, OCL_DONE}, 0, got, lat);
      check_word("done with unit 2", got, 32'd4);
      host_write({8'h01, DONE_OFFSET}, $urandom | 32'd1, 0, lat);
      host_read({8'h00, OCL_DONE}, 0, got, lat);
      check_word("done with both units", got, 32'd6);
      host_write({ID_ALL_UNITS, DONE_OFFSET}, 32'd0, 0, lat);
      host_read({8'h00, OCL_DONE}, 0, got, lat);
      check_word("done after clear", got, 32'd0);
   endtask

   task automatic back_pressure();
      logic [31:0] d;
      logic [31:0] got;
      logic [7:0]  off;
      int          lat;
      off = {2'b00, 4'($urandom_range(0, 14)), 2'b00};
      d = $urandom;
      host_write({8'h01, off}, d, $urandom_range(1, 10), lat);
      unit_model[1][off[5:2]] = d;
      host_read({8'h01, off}, $urandom_range(1, 10), got, lat);
      check_word("held unit 1 read", got, unit_model[1][off[5:2]]);
      host_read({8'h00, OCL_PARAM_N_UNITS}, $urandom_range(1, 10), got, lat);
      check_word("held unit count read", got, 32'(N_UNITS));
      d = $urandom;
      host_write({8'h02, off}, d, 0, lat);      // Normal traffic afterwards
      unit_model[2][off[5:2]] = d;
      host_read({8'h02, off}, 0, got, lat);
      check_word("unit 2 read after hold", got, unit_model[2][off[5:2]]);
   endtask

   initial begin
      void'($urandom(23666));
      clk = 1'b0;
      rstn = 1'b0;
      ocl_awvalid = 1'b0;
      ocl_awaddr = '0;
      ocl_wvalid = 1'b0;
      ocl_wdata = '0;
      ocl_bready = 1'b0;
      ocl_arvalid = 1'b0;
      ocl_araddr = '0;
      ocl_rready = 1'b0;
      n_checks = 0;
      n_errors = 0;
      for (int u = 0; u < ID_LAST; u++) begin
         for (int k = 0; k < N_TILE_REGS; k++) begin
            unit_model[u][k] = '0;              // Registers clear at reset
         end
      end
      repeat (2) @(negedge clk);
      rstn = 1'b1;

      regs_readback();
      task_fifo_order();
      l1_window();
      counter_and_params();
      done_summary();
      back_pressure();

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/tile_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tile_chk import swarm_pkg::*; (
   input logic        clk,
   input logic        rstn,
   input ocl_state_t  state,
   input logic        ocl_awready,
   input logic        ocl_wready,
   input logic        ocl_bvalid,
   input logic        ocl_bready,
   input logic        ocl_rvalid,
   input logic        ocl_rready,
   input logic [31:0] ocl_rdata,
   input logic        l1_rvalid,
   input logic        l1_rready
);

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
      ocl_bvalid && !ocl_bready |=> ocl_bvalid)
      else $error("bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
      ocl_rvalid && !ocl_rready |=> ocl_rvalid && $stable(ocl_rdata))
      else $error("rvalid or rdata changed before rready");

   a_aw_w_excl: assert property (@(posedge clk) disable iff (!rstn)
      !(ocl_awready && ocl_wready))
      else $error("awready and wready high together");

   a_l1_rready: assert property (@(posedge clk) disable iff (!rstn)
      l1_rvalid |-> (state == WAIT_R) && l1_rready)   // L1 answers only a waiting slave
      else $error("l1_rvalid high outside WAIT_R or without l1_rready");

endmodule

bind ocl_slave tile_chk u_tile_chk (
   .clk(clk), .rstn(rstn), .state(state),
   .ocl_awready(ocl_awready), .ocl_wready(ocl_wready),
   .ocl_bvalid(ocl_bvalid), .ocl_bready(ocl_bready),
   .ocl_rvalid(ocl_rvalid), .ocl_rready(ocl_rready), .ocl_rdata(ocl_rdata),
   .l1_rvalid(l1_rvalid), .l1_rready(l1_rready)
);

`default_nettype wire

//--- project.f
src/swarm_pkg.sv
src/ocl_slave.sv
src/tile_regs.sv
src/task_queue.sv
src/l1_mem.sv
src/tile_top.sv
dv/tile_chk.sv
dv/tb_tile.sv

//--- run.sh
#!/usr/bin/env bash
# Build the tile testbench with Verilator, run it and scan the log for failure
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tile -f project.f \
   && ./obj_dir/Vtb_tile 2>&1 | tee sim.log \
   && ! grep -q "=== FAIL ===" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- src/l1_mem.sv
`timescale 1ns/1ps
`default_nettype none

module l1_mem import swarm_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        l1_awvalid,
   input  logic [31:0] l1_awaddr,
   input  logic [31:0] l1_wdata,
   input  logic        l1_arvalid,
   input  logic [31:0] l1_araddr,
   input  logic        l1_rready,
   output logic        l1_awready,
   output logic        l1_arready,
   output logic        l1_bvalid,
   output logic        l1_rvalid,
   output logic [31:0] l1_rdata
);

   logic [31:0]             mem [L1_WORDS];
   logic [L1_CNT_WIDTH-1:0] cnt;
   logic                    busy;
   logic                    rd;
   logic                    accept_w;
   logic                    accept_r;
   logic                    last;

   assign l1_awready = !busy;
   assign l1_arready = !busy && !l1_awvalid;      // Write first
   assign accept_w = l1_awvalid && l1_awready;
   assign accept_r = l1_arvalid && l1_arready;
   assign last = busy && (cnt == L1_CNT_WIDTH'(1));
   assign l1_bvalid = last && !rd;
   assign l1_rvalid = last && rd;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
         rd <= 1'b0;
         cnt <= '0;
      end else if (accept_w || accept_r) begin
         busy <= 1'b1;
         rd <= accept_r;
         cnt <= L1_CNT_WIDTH'(L1_LATENCY);
      end else if (busy) begin
         if (!last) cnt <= cnt - 1'b1;
         else if (!rd || l1_rready) busy <= 1'b0; // Read data held until taken
      end
   end

   always_ff @(posedge clk) begin
      if (accept_w) mem[l1_awaddr[LOG_L1_WORDS+1:2]] <= l1_wdata;
      if (accept_r) l1_rdata <= mem[l1_araddr[LOG_L1_WORDS+1:2]];
   end

endmodule

`default_nettype wire

//--- src/ocl_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ocl_slave import swarm_pkg::*; (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         ocl_awvalid,
   output logic                         ocl_awready,
   input  logic [15:0]                  ocl_awaddr,
   input  logic                         ocl_wvalid,
   output logic                         ocl_wready,
   input  logic [31:0]                  ocl_wdata,
   output logic                         ocl_bvalid,
   input  logic                         ocl_bready,
   input  logic                         ocl_arvalid,
   output logic                         ocl_arready,
   input  logic [15:0]                  ocl_araddr,
   output logic                         ocl_rvalid,
   input  logic                         ocl_rready,
   output logic [31:0]                  ocl_rdata,
   output logic [7:0]                   reg_waddr,
   output logic [31:0]                  reg_wdata,
   output logic [ID_LAST-1:0]           reg_wvalid,
   output logic [7:0]                   reg_araddr,
   output logic [ID_LAST-1:0]           reg_arvalid,
   input  logic [ID_LAST-1:0]           reg_rvalid,
   input  logic [ID_LAST-1:0][31:0]     reg_rdata,
   output logic                         task_wvalid,
   output logic [TS_WIDTH-1:0]          task_ts,
   output logic [LOCALE_WIDTH-1:0]      task_locale,
   output logic [TTYPE_WIDTH-1:0]       task_ttype,
   input  logic                         task_wready,
   output logic                         task_arvalid,
   input  logic                         task_rvalid,
   input  logic [TS_WIDTH-1:0]          task_rts,
   input  logic [LOCALE_WIDTH-1:0]      task_rlocale,
   output logic                         l1_awvalid,
   output logic [31:0]                  l1_awaddr,
   output logic [31:0]                  l1_wdata,
   input  logic                         l1_awready,
   input  logic                         l1_bvalid,
   output logic                         l1_arvalid,
   output logic [31:0]                  l1_araddr,
   input  logic                         l1_arready,
   input  logic                         l1_rvalid,
   output logic                         l1_rready,
   input  logic [31:0]                  l1_rdata,
   input  logic [ID_LAST-1:0]           done
);

   ocl_state_t  state;
   logic [15:0] addr;
   logic [31:0] data;
   logic [31:0] mem_addr;
   logic [63:0] cur_cycle;
   logic [31:0] mem_start;
   logic [31:0] last_mem_latency;
   logic [31:0] csr_rdata;
   logic [31:0] bus_rdata;
   logic [7:0]  unit;
   logic [7:0]  off;
   logic        unit0;
   logic        is_mem;
   logic        is_enq;
   logic        bus_hit;
   logic        bus_rvalid;

   assign unit = addr[15:8];
   assign off = addr[7:0];
   assign unit0 = (unit == 8'h00);
   assign is_mem = unit0 && (off == OCL_ACCESS_MEM);
   assign is_enq = unit0 && (off == OCL_TASK_ENQ);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= IDLE;
         last_mem_latency <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (ocl_awvalid) begin         // Write wins a tie
                  addr <= ocl_awaddr;
                  state <= WAIT_W;
               end else if (ocl_arvalid) begin
                  addr <= ocl_araddr;
                  state <= SEND_AR;
               end
            end
            WAIT_W: begin
               if (ocl_wvalid) begin
                  data <= ocl_wdata;
                  state <= SEND_W;
               end
            end
            SEND_W: begin
               if (!unit0) begin
                  state <= SEND_B;            // Bus strobe goes out this cycle
               end else begin
                  case (off)
                     OCL_TASK_ENQ: begin
                        if (task_wready) state <= SEND_B;
                     end
                     OCL_ACCESS_MEM: begin
                        if (l1_awready) begin
                           mem_start <= cur_cycle[31:0];
                           state <= WAIT_B;
                        end
                     end
                     OCL_TASK_ENQ_LOCALE: begin
                        task_locale <= data;
                        state <= SEND_B;
                     end
                     OCL_TASK_ENQ_TTYPE: begin
                        task_ttype <= data[TTYPE_WIDTH-1:0];
                        state <= SEND_B;
                     end
                     OCL_MEM_ADDR: begin
                        mem_addr <= data;
                        state <= SEND_B;
                     end
                     default: state <= SEND_B;
                  endcase
               end
            end
            WAIT_B: begin
               if (l1_bvalid) begin
                  last_mem_latency <= cur_cycle[31:0] - mem_start;
                  state <= SEND_B;
               end
            end
            SEND_B: begin
               if (ocl_bready) state <= IDLE;
            end
            SEND_AR: begin
               if (!is_mem) begin
                  state <= WAIT_R;
               end else if (l1_arready) begin
                  mem_start <= cur_cycle[31:0];
                  state <= WAIT_R;
               end
            end
            WAIT_R: begin
               if (!unit0) begin
                  if (!bus_hit || bus_rvalid) begin  // Unknown unit reads zero
                     data <= bus_rdata;
                     state <= SEND_R;
                  end
               end else begin
                  case (off)
                     OCL_TASK_ENQ: begin
                        if (task_rvalid) begin
                           data <= task_rts;
                           task_locale <= task_rlocale;
                           state <= SEND_R;
                        end
                     end
                     OCL_ACCESS_MEM: begin
                        if (l1_rvalid) begin
                           data <= l1_rdata;
                           last_mem_latency <= cur_cycle[31:0] - mem_start;
                           state <= SEND_R;
                        end
                     end
                     default: begin
                        data <= csr_rdata;
                        state <= SEND_R;
                     end
                  endcase
               end
            end
            SEND_R: begin
               if (ocl_rready) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_cycle <= '0;
      end else begin
         cur_cycle <= cur_cycle + 64'd1;
      end
   end

   // Unit 0 registers that answer without waiting
   always_comb begin
      case (off)
         OCL_TASK_ENQ_LOCALE: csr_rdata = task_locale;
         OCL_CUR_CYCLE_LSB: csr_rdata = cur_cycle[31:0];
         OCL_CUR_CYCLE_MSB: csr_rdata = cur_cycle[63:32];
         OCL_LAST_MEM_LATENCY: csr_rdata = last_mem_latency;
         OCL_DONE: csr_rdata = 32'(done);
         OCL_PARAM_N_UNITS: csr_rdata = 32'(N_UNITS);
         default: csr_rdata = '0;
      endcase
   end

   always_comb begin
      reg_wvalid = '0;
      reg_arvalid = '0;
      bus_hit = 1'b0;
      bus_rvalid = 1'b0;
      bus_rdata = '0;
      for (int i = 1; i < ID_LAST; i++) begin
         if (state == SEND_W && (unit == 8'(i) || unit == ID_ALL_UNITS)) reg_wvalid[i] = 1'b1;
         if (state == SEND_AR && unit == 8'(i)) reg_arvalid[i] = 1'b1;
         if (unit == 8'(i)) begin
            bus_hit = 1'b1;
            bus_rvalid = reg_rvalid[i];
            bus_rdata = reg_rdata[i];
         end
      end
   end

   assign reg_waddr = off;
   assign reg_wdata = data;
   assign reg_araddr = off;

   assign task_wvalid = (state == SEND_W) && is_enq;
   assign task_ts = data;
   assign task_arvalid = (state == SEND_AR) && is_enq;

   assign l1_awvalid = (state == SEND_W) && is_mem;
   assign l1_awaddr = mem_addr;
   assign l1_wdata = data;
   assign l1_arvalid = (state == SEND_AR) && is_mem;
   assign l1_araddr = mem_addr;
   assign l1_rready = (state == WAIT_R);

   assign ocl_awready = (state == IDLE);
   assign ocl_arready = (state == IDLE) && !ocl_awvalid;
   assign ocl_wready = (state == WAIT_W);
   assign ocl_bvalid = (state == SEND_B);
   assign ocl_rvalid = (state == SEND_R);
   assign ocl_rdata = data;

endmodule

`default_nettype wire

//--- src/swarm_pkg.sv
`default_nettype none

package swarm_pkg;

   // Register bus units with index 0 as the slave itself
   localparam int N_UNITS = 3;
   localparam int ID_LAST = N_UNITS;
   localparam logic [7:0] ID_ALL_UNITS = 8'hF0;   // Broadcast to units 1 and 2

   localparam int TQ_DEPTH = 8;
   localparam int LOG_TQ_DEPTH = 3;

   localparam int L1_WORDS = 256;
   localparam int LOG_L1_WORDS = 8;
   localparam int L1_LATENCY = 4;
   localparam int L1_CNT_WIDTH = $clog2(L1_LATENCY + 1);

   localparam int TS_WIDTH = 32;
   localparam int LOCALE_WIDTH = 32;
   localparam int TTYPE_WIDTH = 2;

   localparam int N_TILE_REGS = 16;

   // Unit 0 register map
   localparam logic [7:0] OCL_TASK_ENQ = 8'h00;
   localparam logic [7:0] OCL_TASK_ENQ_LOCALE = 8'h04;
   localparam logic [7:0] OCL_TASK_ENQ_TTYPE = 8'h08;
   localparam logic [7:0] OCL_ACCESS_MEM = 8'h10;
   localparam logic [7:0] OCL_MEM_ADDR = 8'h14;
   localparam logic [7:0] OCL_CUR_CYCLE_LSB = 8'h20;
   localparam logic [7:0] OCL_CUR_CYCLE_MSB = 8'h24;
   localparam logic [7:0] OCL_LAST_MEM_LATENCY = 8'h28;
   localparam logic [7:0] OCL_DONE = 8'h2C;
   localparam logic [7:0] OCL_PARAM_N_UNITS = 8'h30;

   localparam logic [7:0] DONE_OFFSET = 8'h3C;    // Within a tile_regs unit

   typedef enum logic [3:0] {
      IDLE,
      WAIT_W,
      SEND_W,
      WAIT_B,
      SEND_B,
      SEND_AR,
      WAIT_R,
      SEND_R,
      SPARE
   } ocl_state_t;

endpackage

`default_nettype wire

//--- src/task_queue.sv
`timescale 1ns/1ps
`default_nettype none

module task_queue import swarm_pkg::*; (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    task_wvalid,
   input  logic [TS_WIDTH-1:0]     task_ts,
   input  logic [LOCALE_WIDTH-1:0] task_locale,
   input  logic [TTYPE_WIDTH-1:0]  task_ttype,
   output logic                    task_wready,
   input  logic                    task_arvalid,
   output logic                    task_rvalid,
   output logic [TS_WIDTH-1:0]     task_rts,
   output logic [LOCALE_WIDTH-1:0] task_rlocale
);

   logic [TS_WIDTH-1:0]     ts_q     [TQ_DEPTH];
   logic [LOCALE_WIDTH-1:0] locale_q [TQ_DEPTH];
   logic [TTYPE_WIDTH-1:0]  ttype_q  [TQ_DEPTH];
   logic [LOG_TQ_DEPTH-1:0] wptr;
   logic [LOG_TQ_DEPTH-1:0] rptr;
   logic [LOG_TQ_DEPTH:0]   count;
   logic                    empty;
   logic                    push;
   logic                    pop;

   assign empty = (count == '0);
   assign task_wready = (count != (LOG_TQ_DEPTH + 1)'(TQ_DEPTH));
   assign push = task_wvalid && task_wready;
   assign pop = task_arvalid && !empty;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wptr <= '0;
         rptr <= '0;
         count <= '0;
         task_rvalid <= 1'b0;
      end else begin
         if (push) wptr <= wptr + 1'b1;
         if (pop) rptr <= rptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
         task_rvalid <= task_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ts_q[wptr] <= task_ts;
         locale_q[wptr] <= task_locale;
         ttype_q[wptr] <= task_ttype;
      end
      if (task_arvalid) begin
         task_rts <= empty ? '1 : ts_q[rptr];     // All ones marks an empty queue
         task_rlocale <= empty ? '0 : locale_q[rptr];
      end
   end

endmodule

`default_nettype wire

//--- src/tile_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tile_regs import swarm_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        reg_wvalid,
   input  logic [7:0]  reg_waddr,
   input  logic [31:0] reg_wdata,
   input  logic        reg_arvalid,
   input  logic [7:0]  reg_araddr,
   output logic        reg_rvalid,
   output logic [31:0] reg_rdata,
   output logic        done
);

   logic [31:0] regs [N_TILE_REGS];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < N_TILE_REGS; i++) begin
            regs[i] <= '0;
         end
         reg_rvalid <= 1'b0;
      end else begin
         if (reg_wvalid) regs[reg_waddr[5:2]] <= reg_wdata;
         reg_rvalid <= reg_arvalid;               // Answer exactly one cycle later
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) reg_rdata <= regs[reg_araddr[5:2]];
   end

   assign done = |regs[DONE_OFFSET[5:2]];

endmodule

`default_nettype wire

//--- src/tile_top.sv
`timescale 1ns/1ps
`default_nettype none

module tile_top import swarm_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        ocl_awvalid,
   output logic        ocl_awready,
   input  logic [15:0] ocl_awaddr,
   input  logic        ocl_wvalid,
   output logic        ocl_wready,
   input  logic [31:0] ocl_wdata,
   output logic        ocl_bvalid,
   input  logic        ocl_bready,
   input  logic        ocl_arvalid,
   output logic        ocl_arready,
   input  logic [15:0] ocl_araddr,
   output logic        ocl_rvalid,
   input  logic        ocl_rready,
   output logic [31:0] ocl_rdata
);

   logic [7:0]                   reg_waddr;
   logic [31:0]                  reg_wdata;
   logic [ID_LAST-1:0]           reg_wvalid;
   logic [7:0]                   reg_araddr;
   logic [ID_LAST-1:0]           reg_arvalid;
   logic [ID_LAST-1:0]           reg_rvalid;
   logic [ID_LAST-1:0][31:0]     reg_rdata;
   logic [ID_LAST-1:0]           done;
   logic                         task_wvalid;
   logic [TS_WIDTH-1:0]          task_ts;
   logic [LOCALE_WIDTH-1:0]      task_locale;
   logic [TTYPE_WIDTH-1:0]       task_ttype;
   logic                         task_wready;
   logic                         task_arvalid;
   logic                         task_rvalid;
   logic [TS_WIDTH-1:0]          task_rts;
   logic [LOCALE_WIDTH-1:0]      task_rlocale;
   logic                         l1_awvalid;
   logic [31:0]                  l1_awaddr;
   logic [31:0]                  l1_wdata;
   logic                         l1_awready;
   logic                         l1_bvalid;
   logic                         l1_arvalid;
   logic [31:0]                  l1_araddr;
   logic                         l1_arready;
   logic                         l1_rvalid;
   logic                         l1_rready;
   logic [31:0]                  l1_rdata;

   // Slot 0 is the slave itself
   assign reg_rvalid[0] = 1'b0;
   assign reg_rdata[0] = '0;
   assign done[0] = 1'b0;

   ocl_slave u_ocl_slave (
      .clk(clk), .rstn(rstn),
      .ocl_awvalid(ocl_awvalid), .ocl_awready(ocl_awready), .ocl_awaddr(ocl_awaddr),
      .ocl_wvalid(ocl_wvalid), .ocl_wready(ocl_wready), .ocl_wdata(ocl_wdata),
      .ocl_bvalid(ocl_bvalid), .ocl_bready(ocl_bready),
      .ocl_arvalid(ocl_arvalid), .ocl_arready(ocl_arready), .ocl_araddr(ocl_araddr),
      .ocl_rvalid(ocl_rvalid), .ocl_rready(ocl_rready), .ocl_rdata(ocl_rdata),
      .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wvalid(reg_wvalid),
      .reg_araddr(reg_araddr), .reg_arvalid(reg_arvalid),
      .reg_rvalid(reg_rvalid), .reg_rdata(reg_rdata),
      .task_wvalid(task_wvalid), .task_ts(task_ts), .task_locale(task_locale),
      .task_ttype(task_ttype), .task_wready(task_wready), .task_arvalid(task_arvalid),
      .task_rvalid(task_rvalid), .task_rts(task_rts), .task_rlocale(task_rlocale),
      .l1_awvalid(l1_awvalid), .l1_awaddr(l1_awaddr), .l1_wdata(l1_wdata),
      .l1_awready(l1_awready), .l1_bvalid(l1_bvalid),
      .l1_arvalid(l1_arvalid), .l1_araddr(l1_araddr), .l1_arready(l1_arready),
      .l1_rvalid(l1_rvalid), .l1_rready(l1_rready), .l1_rdata(l1_rdata),
      .done(done)
   );

   for (genvar u = 1; u < ID_LAST; u++) begin : g_unit
      tile_regs u_tile_regs (
         .clk(clk), .rstn(rstn),
         .reg_wvalid(reg_wvalid[u]), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
         .reg_arvalid(reg_arvalid[u]), .reg_araddr(reg_araddr),
         .reg_rvalid(reg_rvalid[u]), .reg_rdata(reg_rdata[u]),
         .done(done[u])
      );
   end

   task_queue u_task_queue (
      .clk(clk), .rstn(rstn),
      .task_wvalid(task_wvalid), .task_ts(task_ts), .task_locale(task_locale),
      .task_ttype(task_ttype), .task_wready(task_wready), .task_arvalid(task_arvalid),
      .task_rvalid(task_rvalid), .task_rts(task_rts), .task_rlocale(task_rlocale)
   );

   l1_mem u_l1_mem (
      .clk(clk), .rstn(rstn),
      .l1_awvalid(l1_awvalid), .l1_awaddr(l1_awaddr), .l1_wdata(l1_wdata),
      .l1_arvalid(l1_arvalid), .l1_araddr(l1_araddr), .l1_rready(l1_rready),
      .l1_awready(l1_awready), .l1_arready(l1_arready),
      .l1_bvalid(l1_bvalid), .l1_rvalid(l1_rvalid), .l1_rdata(l1_rdata)
   );

endmodule

`default_nettype wire
